//--- hw/ppu_pkg.sv
package ppu_pkg;

  // ==================================================
  // Data widths
  // ==================================================
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [12:0] vram_addr_t;
  typedef logic [1:0]  color_id_t;
  typedef logic [1:0]  shade_t;
  typedef logic [8:0]  dot_t;
  typedef logic [3:0]  fifo_ptr_t;
  typedef logic [4:0]  fifo_count_t;

  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_t;

  // ==================================================
  // Line and frame timing
  // ==================================================
  localparam int cycles_per_line = 456;
  localparam int lines_per_frame = 154;
  localparam int visible_lines   = 144;
  localparam int oam_len         = 80;
  localparam int draw_len        = 172;
  localparam int screen_width    = 160;
  localparam int fifo_depth      = 16;

  // CPU address map
  localparam addr_t addr_lcdc = 16'hFF40;
  localparam addr_t addr_scy  = 16'hFF42;
  localparam addr_t addr_scx  = 16'hFF43;
  localparam addr_t addr_ly   = 16'hFF44;
  localparam addr_t addr_bgp  = 16'hFF47;
  localparam addr_t vram_base = 16'h8000;
  localparam int    vram_size = 8192;

endpackage

//--- hw/vram_bus_if.sv
interface vram_bus_if import ppu_pkg::*; ();

  logic       req;
  logic       we;
  vram_addr_t addr;
  byte_t      wdata;
  logic       gnt;
  // Valid the cycle after gnt
  byte_t      rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport memory (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

//--- hw/vram_shared.sv
module vram_shared import ppu_pkg::*; (
  input logic           clk,
  input logic           reset,
  vram_bus_if.memory    cpu_port,
  vram_bus_if.memory    fetch_port
);

  byte_t      mem [vram_size];
  byte_t      rd_q;
  vram_addr_t sel_addr;
  byte_t      sel_wdata;
  logic       sel_we;
  logic       fetch_sel_q;
  logic       cpu_sel_q;

  // Fetcher always wins, CPU only gets idle cycles
  assign fetch_port.gnt = fetch_port.req;
  assign cpu_port.gnt   = cpu_port.req && !fetch_port.req;

  always_comb begin
    if (fetch_port.req) begin
      sel_addr  = fetch_port.addr;
      sel_wdata = fetch_port.wdata;
      sel_we    = fetch_port.we;
    end else begin
      sel_addr  = cpu_port.addr;
      sel_wdata = cpu_port.wdata;
      sel_we    = cpu_port.gnt && cpu_port.we;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_we) begin
      mem[sel_addr] <= sel_wdata;
    end
    rd_q <= mem[sel_addr];
  end

  // Remember who owned the array last cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetch_sel_q <= 1'b0;
      cpu_sel_q   <= 1'b0;
    end else begin
      fetch_sel_q <= fetch_port.gnt;
      cpu_sel_q   <= cpu_port.gnt;
    end
  end

  assign fetch_port.rdata = fetch_sel_q ? rd_q : '0;
  assign cpu_port.rdata   = cpu_sel_q ? rd_q : '0;

endmodule

//--- hw/ppu_regs.sv
module ppu_regs import ppu_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  addr_t         paddr,
  input  byte_t         pwdata,
  input  byte_t         ly,
  output byte_t         prdata,
  output logic          pready,
  output logic          pslverr,
  output byte_t         lcdc,
  output byte_t         scy,
  output byte_t         scx,
  output byte_t         bgp,
  vram_bus_if.requester cpu_port
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait_gnt,
    st_read_data
  } apb_state_t;

  apb_state_t state;
  logic       access;
  logic       is_vram;
  logic       is_reg;
  byte_t      reg_rdata;

  assign access  = psel && penable;
  assign is_vram = (paddr >= vram_base) && (paddr < addr_t'(vram_base + vram_size));
  assign is_reg  = paddr inside {addr_lcdc, addr_scy, addr_scx, addr_ly, addr_bgp};
  assign pslverr = access && !is_vram && !is_reg;

  // ==================================================
  // VRAM cycles
  // ==================================================
  assign cpu_port.req   = access && is_vram && (state != st_read_data);
  assign cpu_port.we    = pwrite;
  assign cpu_port.addr  = vram_addr_t'(paddr - vram_base);
  assign cpu_port.wdata = pwdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle, st_wait_gnt: begin
          if (cpu_port.req) begin
            if (cpu_port.gnt) begin
              state <= pwrite ? st_idle : st_read_data;
            end else begin
              state <= st_wait_gnt;
            end
          end
        end
        st_read_data: state <= st_idle;
        default:      state <= st_idle;
      endcase
    end
  end

  // Registers and errors finish at once, VRAM waits on the arbiter
  always_comb begin
    if (state == st_read_data) begin
      pready = 1'b1;
    end else begin
      pready = access && (!is_vram || (pwrite && cpu_port.gnt));
    end
  end

  // ==================================================
  // Register file
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc <= 8'h91;
      scy  <= '0;
      scx  <= '0;
      bgp  <= '0;
    end else if (access && pwrite && is_reg) begin
      case (paddr)
        addr_lcdc: lcdc <= pwdata;
        addr_scy:  scy  <= pwdata;
        addr_scx:  scx  <= pwdata;
        addr_bgp:  bgp  <= pwdata;
        // LY is read only
        default: ;
      endcase
    end
  end

  always_comb begin
    case (paddr)
      addr_lcdc: reg_rdata = lcdc;
      addr_scy:  reg_rdata = scy;
      addr_scx:  reg_rdata = scx;
      addr_ly:   reg_rdata = ly;
      addr_bgp:  reg_rdata = bgp;
      default:   reg_rdata = '0;
    endcase
  end

  assign prdata = (state == st_read_data) ? cpu_port.rdata : reg_rdata;

endmodule

//--- hw/ppu_timing.sv
module ppu_timing import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      lcd_on,
  output ppu_mode_t mode,
  output byte_t     ly,
  output logic      line_start,
  output logic      frame_done
);

  dot_t dot;
  logic line_end;
  logic visible;

  assign line_end = (dot == dot_t'(cycles_per_line - 1));
  assign visible  = (ly < byte_t'(visible_lines));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= '0;
      ly         <= '0;
      mode       <= mode_oam;
      line_start <= 1'b0;
      frame_done <= 1'b0;
    end else if (!lcd_on) begin
      // Display off holds everything parked
      dot        <= '0;
      ly         <= '0;
      mode       <= mode_hblank;
      line_start <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      line_start <= 1'b0;
      frame_done <= 1'b0;
      if (line_end) begin
        dot <= '0;
        if (ly == byte_t'(lines_per_frame - 1)) begin
          ly         <= '0;
          mode       <= mode_oam;
          frame_done <= 1'b1;
        end else begin
          ly   <= ly + 8'd1;
          mode <= (ly >= byte_t'(visible_lines - 1)) ? mode_vblank : mode_oam;
        end
      end else begin
        dot <= dot + 9'd1;
        // Draw occupies dots 80 to 251 of a visible line
        if (visible && dot == dot_t'(oam_len - 1)) begin
          mode       <= mode_draw;
          line_start <= 1'b1;
        end else if (visible && dot == dot_t'(oam_len + draw_len - 1)) begin
          mode <= mode_hblank;
        end
      end
    end
  end

endmodule

//--- hw/bg_fetcher.sv
module bg_fetcher import ppu_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  ppu_mode_t     mode,
  input  logic          line_start,
  input  byte_t         ly,
  input  byte_t         lcdc,
  input  byte_t         scx,
  input  byte_t         scy,
  input  logic          full,
  output logic          push,
  output color_id_t     push_id,
  output logic          flush,
  vram_bus_if.requester fetch_port
);

  typedef enum logic [2:0] {
    f_idle,
    f_map_req,
    f_low_req,
    f_high_req,
    f_high_data,
    f_hold
  } fetch_state_t;

  fetch_state_t state;
  byte_t        row_q;
  byte_t        row_now;
  logic [4:0]   tile_x;
  logic [4:0]   tile_cnt;
  byte_t        tile_q;
  byte_t        tile_id;
  logic         map_fresh;
  logic         low_fresh;
  byte_t        lo_q;
  byte_t        hi_q;
  byte_t        lo_sh;
  byte_t        hi_sh;
  logic [3:0]   pix_left;
  logic         drawing;
  logic         shift_free;
  logic         load;

  function automatic vram_addr_t map_addr(input logic map_sel, input byte_t row,
                                          input logic [4:0] col);
    return {2'b11, map_sel, row[7:3], col};
  endfunction

  // Bit 12 set selects the 0x1000 based signed area
  function automatic vram_addr_t tile_addr(input logic unsigned_mode, input byte_t tile,
                                           input logic [2:0] fine_y, input logic hi);
    return {~(unsigned_mode | tile[7]), tile, fine_y, hi};
  endfunction

  assign row_now    = ly + scy;
  assign drawing    = (mode == mode_draw);
  assign flush      = line_start;
  assign push       = drawing && (pix_left != 4'd0) && !full;
  assign push_id    = {hi_sh[7], lo_sh[7]};
  assign shift_free = (pix_left == 4'd0) || (pix_left == 4'd1 && push);
  assign load       = drawing && !line_start && shift_free &&
                      (state == f_high_data || state == f_hold);
  assign tile_id    = map_fresh ? fetch_port.rdata : tile_q;

  // ==================================================
  // VRAM requests
  // ==================================================
  always_comb begin
    fetch_port.we    = 1'b0;
    fetch_port.wdata = '0;
    fetch_port.req   = line_start || state == f_map_req || state == f_low_req ||
                       state == f_high_req;
    if (line_start) begin
      // First map read goes out in the line start cycle
      fetch_port.addr = map_addr(lcdc[3], row_now, scx[7:3]);
    end else begin
      case (state)
        f_low_req:  fetch_port.addr = tile_addr(lcdc[4], tile_id, row_q[2:0], 1'b0);
        f_high_req: fetch_port.addr = tile_addr(lcdc[4], tile_q, row_q[2:0], 1'b1);
        default:    fetch_port.addr = map_addr(lcdc[3], row_q, tile_x);
      endcase
    end
  end

  // ==================================================
  // Fetch FSM
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= f_idle;
      row_q     <= '0;
      tile_x    <= '0;
      tile_cnt  <= '0;
      map_fresh <= 1'b0;
      low_fresh <= 1'b0;
      pix_left  <= '0;
    end else begin
      map_fresh <= 1'b0;
      low_fresh <= 1'b0;
      if (push) begin
        pix_left <= pix_left - 4'd1;
      end
      if (line_start) begin
        row_q     <= row_now;
        tile_x    <= scx[7:3];
        tile_cnt  <= '0;
        pix_left  <= '0;
        map_fresh <= fetch_port.gnt;
        state     <= fetch_port.gnt ? f_low_req : f_map_req;
      end else if (!drawing) begin
        state    <= f_idle;
        pix_left <= '0;
      end else begin
        case (state)
          f_map_req: begin
            if (fetch_port.gnt) begin
              map_fresh <= 1'b1;
              state     <= f_low_req;
            end
          end
          f_low_req: begin
            if (fetch_port.gnt) begin
              low_fresh <= 1'b1;
              state     <= f_high_req;
            end
          end
          f_high_req: begin
            if (fetch_port.gnt) begin
              state <= f_high_data;
            end
          end
          f_high_data, f_hold: begin
            if (load) begin
              pix_left <= 4'd8;
              tile_x   <= tile_x + 5'd1;
              tile_cnt <= tile_cnt + 5'd1;
              // 21 tiles cover 160 pixels plus the fine scroll
              state    <= (tile_cnt == 5'(screen_width / 8)) ? f_idle : f_map_req;
            end else begin
              state <= f_hold;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Tile data and pixel shifter
  always_ff @(posedge clk) begin
    if (state == f_low_req) begin
      tile_q <= tile_id;
    end
    if (low_fresh) begin
      lo_q <= fetch_port.rdata;
    end
    if (state == f_high_data) begin
      hi_q <= fetch_port.rdata;
    end
    if (load) begin
      lo_sh <= lo_q;
      hi_sh <= (state == f_high_data) ? fetch_port.rdata : hi_q;
    end else if (push) begin
      lo_sh <= {lo_sh[6:0], 1'b0};
      hi_sh <= {hi_sh[6:0], 1'b0};
    end
  end

endmodule

//--- hw/pixel_fifo.sv
module pixel_fifo import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      flush,
  input  logic      push,
  input  color_id_t push_id,
  input  logic      pop,
  output color_id_t pop_id,
  output logic      full,
  output logic      empty
);

  color_id_t   mem [fifo_depth];
  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   rd_ptr;
  fifo_count_t count;
  logic        do_push;
  logic        do_pop;

  assign full    = (count == fifo_count_t'(fifo_depth));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign pop_id  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_id;
    end
  end

  // Pointers wrap on their own at 16
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 4'd1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
      if (do_push && !do_pop) begin
        count <= count + 5'd1;
      end else if (do_pop && !do_push) begin
        count <= count - 5'd1;
      end
    end
  end

endmodule

//--- hw/pixel_out.sv
module pixel_out import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      line_start,
  input  byte_t     scx,
  input  byte_t     bgp,
  input  byte_t     lcdc,
  input  logic      empty,
  input  color_id_t pop_id,
  output logic      pop,
  output logic      pixel_valid,
  output shade_t    pixel_shade
);

  logic       active;
  logic [2:0] drop_left;
  byte_t      x_cnt;
  color_id_t  id_eff;

  assign pop         = active && !empty;
  assign pixel_valid = pop && (drop_left == 3'd0);

  // Background disabled shows colour 0 everywhere
  assign id_eff      = lcdc[0] ? pop_id : '0;
  assign pixel_shade = bgp[{id_eff, 1'b0} +: 2];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active    <= 1'b0;
      drop_left <= '0;
      x_cnt     <= '0;
    end else if (line_start) begin
      active    <= 1'b1;
      drop_left <= scx[2:0];
      x_cnt     <= '0;
    end else if (pop) begin
      if (drop_left != 3'd0) begin
        // Fine scroll pixels go nowhere
        drop_left <= drop_left - 3'd1;
      end else begin
        x_cnt <= x_cnt + 8'd1;
        if (x_cnt == byte_t'(screen_width - 1)) begin
          active <= 1'b0;
        end
      end
    end
  end

endmodule

//--- hw/ppu_top.sv
module ppu_top import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  addr_t     paddr,
  input  byte_t     pwdata,
  output byte_t     prdata,
  output logic      pready,
  output logic      pslverr,
  output ppu_mode_t mode,
  output byte_t     ly,
  output logic      frame_done,
  output logic      pixel_valid,
  output shade_t    pixel_shade
);

  byte_t     lcdc;
  byte_t     scy;
  byte_t     scx;
  byte_t     bgp;
  logic      line_start;
  logic      push;
  logic      pop;
  logic      flush;
  logic      full;
  logic      empty;
  color_id_t push_id;
  color_id_t pop_id;

  vram_bus_if cpu_port ();
  vram_bus_if fetch_port ();

  // ==================================================
  // CPU side and shared memory
  // ==================================================
  ppu_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .ly       (ly),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .lcdc     (lcdc),
    .scy      (scy),
    .scx      (scx),
    .bgp      (bgp),
    .cpu_port (cpu_port.requester)
  );

  vram_shared u_vram (
    .clk        (clk),
    .reset      (reset),
    .cpu_port   (cpu_port.memory),
    .fetch_port (fetch_port.memory)
  );

  // ==================================================
  // Video pipeline
  // ==================================================
  ppu_timing u_timing (
    .clk        (clk),
    .reset      (reset),
    .lcd_on     (lcdc[7]),
    .mode       (mode),
    .ly         (ly),
    .line_start (line_start),
    .frame_done (frame_done)
  );

  bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .line_start (line_start),
    .ly         (ly),
    .lcdc       (lcdc),
    .scx        (scx),
    .scy        (scy),
    .full       (full),
    .push       (push),
    .push_id    (push_id),
    .flush      (flush),
    .fetch_port (fetch_port.requester)
  );

  pixel_fifo u_fifo (
    .clk     (clk),
    .reset   (reset),
    .flush   (flush),
    .push    (push),
    .push_id (push_id),
    .pop     (pop),
    .pop_id  (pop_id),
    .full    (full),
    .empty   (empty)
  );

  pixel_out u_pixel_out (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .scx         (scx),
    .bgp         (bgp),
    .lcdc        (lcdc),
    .empty       (empty),
    .pop_id      (pop_id),
    .pop         (pop),
    .pixel_valid (pixel_valid),
    .pixel_shade (pixel_shade)
  );

endmodule

//--- sim/tb_ppu.sv
module tb_ppu import ppu_pkg::*; ();

  localparam int frame_cycles   = cycles_per_line * lines_per_frame;
  localparam int timeout_cycles = 4 * frame_cycles + 40000;
  localparam int sample_reads   = 256;

  logic      clk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  addr_t     paddr;
  byte_t     pwdata;
  byte_t     prdata;
  logic      pready;
  logic      pslverr;
  ppu_mode_t mode;
  byte_t     ly;
  logic      frame_done;
  logic      pixel_valid;
  shade_t    pixel_shade;

  byte_t       shadow [vram_size];
  logic [31:0] lcg_state;
  int          cycle_count;
  int          checks;
  int          value_errors;
  int          other_errors;

  // Pixel comparison state
  logic  check_pixels;
  int    line_count [visible_lines];
  byte_t ref_lcdc;
  byte_t ref_scx;
  byte_t ref_scy;
  byte_t ref_bgp;

  // Timing monitor state
  logic  timing_en;
  logic  line_synced;
  logic  frame_synced;
  byte_t prev_ly;
  int    dot_ref;
  int    since_frame;
  int    frame_intervals;

  ppu_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .mode        (mode),
    .ly          (ly),
    .frame_done  (frame_done),
    .pixel_valid (pixel_valid),
    .pixel_shade (pixel_shade)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // Run limit covers the VRAM fill and four frames
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout, the run was still busy after %0d cycles", cycle_count);
    $display("Errors found");
    $finish;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic shade_t ref_pixel(input int x, input int y, input byte_t lcdc_v,
                                       input byte_t scx_v, input byte_t scy_v,
                                       input byte_t bgp_v);
    int        bx;
    int        by;
    int        map_base;
    int        data_base;
    int        bit_pos;
    byte_t     tile;
    byte_t     lo;
    byte_t     hi;
    color_id_t id;
    bx = (x + scx_v) % 256;
    by = (y + scy_v) % 256;
    map_base = lcdc_v[3] ? 'h1C00 : 'h1800;
    tile = shadow[map_base + (by / 8) * 32 + bx / 8];
    // Unsigned tiles from 0x0000, signed ones around 0x1000
    if (lcdc_v[4]) begin
      data_base = int'(tile) * 16;
    end else begin
      data_base = 'h1000 + int'($signed(tile)) * 16;
    end
    lo = shadow[data_base + (by % 8) * 2];
    hi = shadow[data_base + (by % 8) * 2 + 1];
    bit_pos = 7 - bx % 8;
    id = {hi[bit_pos], lo[bit_pos]};
    if (!lcdc_v[0]) begin
      id = 2'd0;
    end
    return shade_t'(bgp_v >> (2 * id));
  endfunction

  function automatic ppu_mode_t expected_mode(input byte_t line, input int dot);
    if (line >= visible_lines) begin
      return mode_vblank;
    end
    if (dot < oam_len) begin
      return mode_oam;
    end
    if (dot < oam_len + draw_len) begin
      return mode_draw;
    end
    return mode_hblank;
  endfunction

  // ==================================================
  // Result checks
  // ==================================================
  task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_shade(input string name, input shade_t got, input shade_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic verify_mode(input string name, input ppu_mode_t got, input ppu_mode_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errors++;
    $display("Problem at %0t: %s", $time, msg);
  endtask

  // ==================================================
  // APB transfers
  // ==================================================
  task automatic apb_write(input addr_t addr, input byte_t data, output logic err);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    err = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input addr_t addr, output byte_t data, output logic err);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_readback(input string name, input addr_t addr, input byte_t value);
    byte_t data;
    logic  err;
    apb_write(addr, value, err);
    if (err) begin
      note_failure($sformatf("write to %s raised pslverr", name));
    end
    apb_read(addr, data, err);
    if (err) begin
      note_failure($sformatf("read of %s raised pslverr", name));
    end
    compare_byte(name, data, value);
  endtask

  task automatic wait_for_line(input int line);
    @(negedge clk);
    while (ly != line) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_for_frame_start();
    @(negedge clk);
    while (!frame_done) begin
      @(negedge clk);
    end
  endtask

  // ==================================================
  // Monitors
  // ==================================================
  always @(negedge clk) begin : pixel_compare
    int x;
    if (check_pixels && pixel_valid) begin
      if (ly >= visible_lines) begin
        note_failure($sformatf("pixel on line %0d outside the visible area", ly));
      end else begin
        x = line_count[ly];
        if (x >= screen_width) begin
          note_failure($sformatf("extra pixel on line %0d", ly));
        end else begin
          check_shade($sformatf("pixel_shade x=%0d y=%0d", x, ly), pixel_shade,
                      ref_pixel(x, ly, ref_lcdc, ref_scx, ref_scy, ref_bgp));
        end
        line_count[ly] = x + 1;
      end
    end
  end

  // Follows LY, the mode schedule and the frame period
  always @(negedge clk) begin
    if (!timing_en) begin
      line_synced  = 1'b0;
      frame_synced = 1'b0;
    end else begin
      since_frame++;
      if (ly != prev_ly) begin
        if (line_synced && dot_ref != cycles_per_line - 1) begin
          note_failure($sformatf("line %0d lasted %0d cycles", prev_ly, dot_ref + 1));
        end
        compare_byte("ly", ly, byte_t'((prev_ly + 1) % lines_per_frame));
        line_synced = 1'b1;
        dot_ref     = 0;
      end else begin
        dot_ref++;
      end
      if (line_synced) begin
        verify_mode("mode", mode, expected_mode(ly, dot_ref));
      end
      if (frame_done) begin
        compare_byte("ly at frame_done", ly, 8'd0);
        if (frame_synced) begin
          if (since_frame != frame_cycles) begin
            note_failure($sformatf("frame_done came %0d cycles after the last one",
                                   since_frame));
          end
          frame_intervals++;
        end
        frame_synced = 1'b1;
        since_frame  = 0;
      end
    end
    prev_ly = ly;
  end

  // ==================================================
  // Tests
  // ==================================================
  task automatic test_registers();
    byte_t data;
    byte_t ly_before;
    logic  err;
    apb_read(addr_lcdc, data, err);
    compare_byte("lcdc after reset", data, 8'h91);
    apb_read(addr_scx, data, err);
    compare_byte("scx after reset", data, 8'h00);
    apb_read(addr_bgp, data, err);
    compare_byte("bgp after reset", data, 8'h00);
    write_readback("lcdc", addr_lcdc, 8'h93);
    write_readback("scy", addr_scy, 8'h5A);
    write_readback("scx", addr_scx, 8'hA7);
    write_readback("bgp", addr_bgp, 8'h6C);
    write_readback("lcdc", addr_lcdc, 8'h91);
    // LY may step to the next line between the reads
    apb_read(addr_ly, ly_before, err);
    apb_write(addr_ly, 8'h77, err);
    if (err) begin
      note_failure("write to LY raised pslverr");
    end
    apb_read(addr_ly, data, err);
    if (data != ly_before) begin
      compare_byte("ly after write", data, byte_t'((ly_before + 1) % lines_per_frame));
    end
    apb_read(16'hFF41, data, err);
    if (!err) begin
      note_failure("read of unmapped 0xFF41 gave no pslverr");
    end
    compare_byte("prdata unmapped", data, 8'h00);
    apb_write(16'hFF50, 8'hA5, err);
    if (!err) begin
      note_failure("write to unmapped 0xFF50 gave no pslverr");
    end
    apb_read(16'h7FFF, data, err);
    if (!err) begin
      note_failure("read of unmapped 0x7FFF gave no pslverr");
    end
  endtask

  task automatic test_vram();
    byte_t       data;
    logic        err;
    logic [31:0] rnd;
    int          offset;
    for (int i = 0; i < vram_size; i++) begin
      rnd = lcg_next();
      shadow[i] = rnd[23:16];
      apb_write(addr_t'(vram_base + i), rnd[23:16], err);
      if (err) begin
        note_failure($sformatf("VRAM write at offset 0x%04h raised pslverr", i));
      end
    end
    for (int n = 0; n < sample_reads; n++) begin
      rnd = lcg_next();
      offset = int'(rnd[28:16]);
      apb_read(addr_t'(vram_base + offset), data, err);
      if (err) begin
        note_failure($sformatf("VRAM read at offset 0x%04h raised pslverr", offset));
      end
      compare_byte($sformatf("vram[0x%04h]", offset), data, shadow[offset]);
    end
  endtask

  task automatic run_frame(input byte_t lcdc_v, input byte_t scx_v, input byte_t scy_v,
                           input byte_t bgp_v);
    logic err;
    int   total;
    // New settings go in during vblank
    wait_for_line(visible_lines + 1);
    apb_write(addr_scx, scx_v, err);
    apb_write(addr_scy, scy_v, err);
    apb_write(addr_bgp, bgp_v, err);
    apb_write(addr_lcdc, lcdc_v, err);
    ref_lcdc = lcdc_v;
    ref_scx  = scx_v;
    ref_scy  = scy_v;
    ref_bgp  = bgp_v;
    for (int i = 0; i < visible_lines; i++) begin
      line_count[i] = 0;
    end
    wait_for_frame_start();
    check_pixels = 1'b1;
    wait_for_line(visible_lines);
    check_pixels = 1'b0;
    total = 0;
    for (int i = 0; i < visible_lines; i++) begin
      total += line_count[i];
      if (line_count[i] != screen_width) begin
        note_failure($sformatf("line %0d gave %0d pixels", i, line_count[i]));
      end
    end
    $display("Frame with scx %0d scy %0d compared %0d pixels", scx_v, scy_v, total);
  endtask

  task automatic test_lcd_off();
    byte_t data;
    logic  err;
    int    stray;
    wait_for_line(visible_lines + 1);
    timing_en = 1'b0;
    apb_write(addr_lcdc, 8'h11, err);
    // Counters park one edge after LCDC changes
    @(posedge clk);
    stray = 0;
    repeat (2 * cycles_per_line) begin
      @(negedge clk);
      if (pixel_valid) begin
        stray++;
      end
      verify_mode("mode with lcd off", mode, mode_hblank);
      compare_byte("ly with lcd off", ly, 8'd0);
    end
    if (stray != 0) begin
      note_failure($sformatf("%0d pixels came out with the LCD off", stray));
    end
    apb_read(addr_ly, data, err);
    compare_byte("ly read with lcd off", data, 8'd0);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    reset           = 1'b1;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    check_pixels    = 1'b0;
    timing_en       = 1'b0;
    lcg_state       = 32'd18384;
    checks          = 0;
    value_errors    = 0;
    other_errors    = 0;
    dot_ref         = 0;
    since_frame     = 0;
    frame_intervals = 0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    verify_mode("mode after reset", mode, mode_oam);
    compare_byte("ly after reset", ly, 8'd0);
    if (pready || pixel_valid || frame_done) begin
      note_failure("pready, pixel_valid or frame_done high right after reset");
    end
    timing_en = 1'b1;

    test_registers();
    test_vram();
    run_frame(8'h91, 8'h00, 8'h00, 8'hE4);
    run_frame(8'h89, 8'h05, 8'h03, 8'h1B);
    if (frame_intervals < 1) begin
      note_failure("no full frame period was timed");
    end
    test_lcd_off();

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sim.f
hw/ppu_pkg.sv
hw/vram_bus_if.sv
hw/vram_shared.sv
hw/ppu_regs.sv
hw/ppu_timing.sv
hw/bg_fetcher.sv
hw/pixel_fifo.sv
hw/pixel_out.sv
hw/ppu_top.sv
sim/tb_ppu.sv

//--- Bender.yml
package:
  name: ppu_bg

sources:
  - hw/ppu_pkg.sv
  - hw/vram_bus_if.sv
  - hw/vram_shared.sv
  - hw/ppu_regs.sv
  - hw/ppu_timing.sv
  - hw/bg_fetcher.sv
  - hw/pixel_fifo.sv
  - hw/pixel_out.sv
  - hw/ppu_top.sv
  - target: test
    files:
      - sim/tb_ppu.sv
